//--- logic/dcache_pkg.sv
// Data cache definitions

package dcache_pkg;

	// Geometry
	localparam int ADDR_WIDTH = 32;
	localparam int OFFSET_WIDTH = 6;
	localparam int SET_WIDTH = 5;
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH - OFFSET_WIDTH;
	localparam int NUM_SETS = 1 << SET_WIDTH;
	localparam int NUM_WAYS = 4;
	localparam int WAY_WIDTH = 2;
	localparam int LINE_BYTES = 1 << OFFSET_WIDTH;
	localparam int LINE_BITS = LINE_BYTES * 8;

	// One bit per inner node of the replacement tree
	localparam int LRU_BITS = NUM_WAYS - 1;

	// Miss queue
	localparam int MISS_FIFO_DEPTH = 4;
	localparam int MISS_PTR_WIDTH = 2;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [SET_WIDTH-1:0] set_t;
	typedef logic [WAY_WIDTH-1:0] way_t;
	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [LINE_BYTES-1:0] mask_t;

	// One outstanding miss as seen by the L2 sequencer
	typedef struct packed {
		set_t set_idx;
		way_t way;
		tag_t req_tag;
		tag_t victim_tag;
	} miss_req_t;

	typedef enum logic [1:0] {
		L2_IDLE,
		L2_WRITE,
		L2_READ
	} l2_state_t;

endpackage

//--- logic/way_if.sv
// Cache way signal bundle

`timescale 1ns/10ps

interface way_if import dcache_pkg::*; ();

	// Lookup and core write from the top level
	set_t lookup_set;
	tag_t lookup_tag;
	logic wr_en;
	mask_t wr_mask;
	line_t wr_data;

	// Line maintenance from the miss engine
	logic fill_en;
	set_t fill_set;
	tag_t fill_tag;
	line_t fill_data;
	logic clean_en;
	set_t clean_set;
	logic inval_en;
	set_t inval_set;
	set_t victim_set;

	// Way results
	logic hit;
	line_t rd_line;
	tag_t victim_tag;
	line_t victim_line;
	logic dirty;

	modport owner (
		input lookup_set, lookup_tag, wr_en, wr_mask, wr_data,
		input fill_en, fill_set, fill_tag, fill_data,
		input clean_en, clean_set, inval_en, inval_set, victim_set,
		output hit, rd_line, victim_tag, victim_line, dirty
	);

	modport core (
		output lookup_set, lookup_tag, wr_en, wr_mask, wr_data,
		input hit, rd_line, victim_tag
	);

	modport refill (
		output fill_en, fill_set, fill_tag, fill_data,
		output clean_en, clean_set, inval_en, inval_set, victim_set,
		input victim_line, dirty
	);

endinterface

//--- logic/cache_way.sv
// Single cache way

`timescale 1ns/10ps

module cache_way import dcache_pkg::*; (
	input  logic clk,
	input  logic arst_n_i,
	way_if.owner way_io
);

	tag_t tag_mem [NUM_SETS];
	line_t line_mem [NUM_SETS];
	logic [NUM_SETS-1:0] valid_bits;
	logic [NUM_SETS-1:0] dirty_bits;

	// Lookup stage registers
	set_t set_q;
	tag_t tag_q;
	line_t line_q;
	logic valid_q;

	logic write_hit;

	// Read the addressed set in the access cycle
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= valid_bits[way_io.lookup_set];
		end
	end

	always_ff @(posedge clk)
	begin
		set_q <= way_io.lookup_set;
		tag_q <= tag_mem[way_io.lookup_set];
		line_q <= line_mem[way_io.lookup_set];
	end

	// Tag compare against the latched request
	assign way_io.hit = valid_q && (tag_q == way_io.lookup_tag);
	assign way_io.rd_line = line_q;
	assign way_io.victim_tag = tag_q;

	assign write_hit = way_io.wr_en && way_io.hit;

	// Line and tag storage
	always_ff @(posedge clk)
	begin
		if (way_io.fill_en)
		begin
			line_mem[way_io.fill_set] <= way_io.fill_data;
			tag_mem[way_io.fill_set] <= way_io.fill_tag;
		end

		// Byte-enabled merge of core write data
		if (write_hit)
		begin
			for (int b = 0; b < LINE_BYTES; b++)
			begin
				if (way_io.wr_mask[b])
					line_mem[set_q][b*8 +: 8] <= way_io.wr_data[b*8 +: 8];
			end
		end
	end

	// Valid and dirty state
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else
		begin
			if (way_io.inval_en)
				valid_bits[way_io.inval_set] <= 1'b0;
			if (way_io.fill_en)
				valid_bits[way_io.fill_set] <= 1'b1;

			if (way_io.clean_en)
				dirty_bits[way_io.clean_set] <= 1'b0;
			if (way_io.fill_en)
				dirty_bits[way_io.fill_set] <= 1'b0;
			// Refilled line stays clean until a later write
			if (write_hit)
				dirty_bits[set_q] <= 1'b1;
		end
	end

	// Victim side read for write-back
	assign way_io.dirty = dirty_bits[way_io.victim_set];
	assign way_io.victim_line = line_mem[way_io.victim_set];

	// Refill and core store must target different sets
	fill_write_apart: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		way_io.fill_en && write_hit |-> way_io.fill_set != set_q
	)
	else
		$error("fill and write hit collide in set %0d", set_q);

endmodule

//--- logic/pseudo_lru.sv
// Tree pseudo-LRU replacement

`timescale 1ns/10ps

module pseudo_lru import dcache_pkg::*; (
	input  logic clk,
	input  logic arst_n_i,
	input  set_t lookup_set_i,
	input  logic update_i,
	input  set_t update_set_i,
	input  way_t used_way_i,
	output way_t victim_way_o
);

	// Bit 0 is the root, bit 1 the left child, bit 2 the right child
	logic [NUM_SETS-1:0][LRU_BITS-1:0] tree_bits;
	logic [LRU_BITS-1:0] cur_bits;
	logic [LRU_BITS-1:0] next_bits;

	assign cur_bits = tree_bits[lookup_set_i];

	// Follow the tree down to a leaf
	always_comb
	begin
		if (!cur_bits[0])
			victim_way_o = {1'b0, cur_bits[1]};
		else
			victim_way_o = {1'b1, cur_bits[2]};
	end

	// Point every node on the used path away from it
	always_comb
	begin
		next_bits = tree_bits[update_set_i];
		next_bits[0] = ~used_way_i[1];
		if (used_way_i[1])
			next_bits[2] = ~used_way_i[0];
		else
			next_bits[1] = ~used_way_i[0];
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			tree_bits <= '0;
		end
		else if (update_i)
		begin
			tree_bits[update_set_i] <= next_bits;
		end
	end

	// A way just used is never the next victim of its set
	no_recent_victim: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		update_i ##1 (lookup_set_i == $past(update_set_i))
			|-> victim_way_o != $past(used_way_i)
	)
	else
		$error("victim way %0d was just used", victim_way_o);

endmodule

//--- logic/miss_engine.sv
// Miss queue and L2 sequencer

`timescale 1ns/10ps

module miss_engine import dcache_pkg::*; (
	input  logic clk,
	input  logic arst_n_i,
	input  logic miss_i,
	input  miss_req_t miss_req_i,
	input  logic l2_ack_i,
	input  line_t l2_data_i,
	output logic l2_read_o,
	output logic l2_write_o,
	output addr_t l2_addr_o,
	output line_t l2_data_o,
	way_if.refill ways_io [NUM_WAYS]
);

	miss_req_t fifo_mem [MISS_FIFO_DEPTH];
	logic [MISS_PTR_WIDTH-1:0] wr_ptr;
	logic [MISS_PTR_WIDTH-1:0] rd_ptr;
	logic [MISS_PTR_WIDTH:0] count;
	logic empty;
	logic full;
	miss_req_t head;

	l2_state_t state_q;
	l2_state_t state_d;
	logic start;
	logic clean_strobe;
	logic fill_strobe;

	logic [NUM_WAYS-1:0] way_dirty;
	line_t way_victim_line [NUM_WAYS];

	// Request FIFO
	assign empty = (count == '0);
	assign full = (count == MISS_FIFO_DEPTH);
	assign head = fifo_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (miss_i)
			fifo_mem[wr_ptr] <= miss_req_i;
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (miss_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (fill_strobe)
				rd_ptr <= rd_ptr + 1'b1;
			if (miss_i && !fill_strobe)
				count <= count + 1'b1;
			else if (fill_strobe && !miss_i)
				count <= count - 1'b1;
		end
	end

	// Sequencer
	assign start = (state_q == L2_IDLE) && !empty;
	assign clean_strobe = (state_q == L2_WRITE) && l2_ack_i;
	assign fill_strobe = (state_q == L2_READ) && l2_ack_i;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			L2_IDLE:
			begin
				if (!empty)
					state_d = way_dirty[head.way] ? L2_WRITE : L2_READ;
			end
			L2_WRITE:
			begin
				if (l2_ack_i)
					state_d = L2_READ;
			end
			L2_READ:
			begin
				if (l2_ack_i)
					state_d = L2_IDLE;
			end
			default:
				state_d = L2_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			state_q <= L2_IDLE;
		else
			state_q <= state_d;
	end

	// Strobes go only to the way at the queue head
	for (genvar g = 0; g < NUM_WAYS; g++)
	begin : g_way
		assign way_dirty[g] = ways_io[g].dirty;
		assign way_victim_line[g] = ways_io[g].victim_line;
		assign ways_io[g].victim_set = head.set_idx;
		assign ways_io[g].inval_en = start && (head.way == way_t'(g));
		assign ways_io[g].inval_set = head.set_idx;
		assign ways_io[g].clean_en = clean_strobe && (head.way == way_t'(g));
		assign ways_io[g].clean_set = head.set_idx;
		assign ways_io[g].fill_en = fill_strobe && (head.way == way_t'(g));
		assign ways_io[g].fill_set = head.set_idx;
		assign ways_io[g].fill_tag = head.req_tag;
		assign ways_io[g].fill_data = l2_data_i;
	end

	// L2 port levels held until ack
	assign l2_write_o = (state_q == L2_WRITE);
	assign l2_read_o = (state_q == L2_READ);
	assign l2_data_o = way_victim_line[head.way];

	always_comb
	begin
		if (state_q == L2_WRITE)
			l2_addr_o = {head.victim_tag, head.set_idx, {OFFSET_WIDTH{1'b0}}};
		else
			l2_addr_o = {head.req_tag, head.set_idx, {OFFSET_WIDTH{1'b0}}};
	end

	no_enqueue_full: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		miss_i |-> !full
	)
	else
		$error("miss enqueued while queue full");

	l2_one_request: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!(l2_read_o && l2_write_o)
	)
	else
		$error("L2 read and write raised together");

	l2_addr_held: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		(l2_read_o || l2_write_o) && !l2_ack_i |=> $stable(l2_addr_o)
	)
	else
		$error("L2 address changed before ack");

endmodule

//--- logic/data_cache.sv
// L1 data cache top level

`timescale 1ns/10ps

module data_cache import dcache_pkg::*; (
	input  logic clk,
	input  logic arst_n_i,

	// Core side
	input  logic access_i,
	input  logic write_i,
	input  addr_t address_i,
	input  line_t data_i,
	input  mask_t write_mask_i,
	output line_t data_o,
	output logic cache_hit_o,

	// L2 side
	output logic l2_read_o,
	output logic l2_write_o,
	output addr_t l2_addr_o,
	output line_t l2_data_o,
	input  line_t l2_data_i,
	input  logic l2_ack_i
);

	set_t set_d;
	tag_t tag_d;

	// Request register
	logic access_q;
	logic write_q;
	set_t set_q;
	tag_t tag_q;
	mask_t mask_q;

	logic [NUM_WAYS-1:0] hits;
	line_t way_lines [NUM_WAYS];
	tag_t way_tags [NUM_WAYS];
	way_t hit_way;
	way_t victim_way;
	way_t used_way;
	logic miss;
	miss_req_t miss_req;

	way_if ways [NUM_WAYS] ();

	assign set_d = address_i[OFFSET_WIDTH +: SET_WIDTH];
	assign tag_d = address_i[ADDR_WIDTH-1 -: TAG_WIDTH];

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			access_q <= 1'b0;
			write_q <= 1'b0;
		end
		else
		begin
			access_q <= access_i;
			write_q <= write_i;
		end
	end

	always_ff @(posedge clk)
	begin
		set_q <= set_d;
		tag_q <= tag_d;
		mask_q <= write_mask_i;
	end

	// Ways see the raw set now and the latched tag next cycle
	for (genvar g = 0; g < NUM_WAYS; g++)
	begin : g_way
		assign ways[g].lookup_set = set_d;
		assign ways[g].lookup_tag = tag_q;
		assign ways[g].wr_en = access_q && write_q;
		assign ways[g].wr_mask = mask_q;
		assign ways[g].wr_data = data_i;
		assign hits[g] = ways[g].hit;
		assign way_lines[g] = ways[g].rd_line;
		assign way_tags[g] = ways[g].victim_tag;

		cache_way i_cache_way (
			.clk(clk),
			.arst_n_i(arst_n_i),
			.way_io(ways[g])
		);
	end

	// Lowest hitting way wins
	always_comb
	begin
		hit_way = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--)
		begin
			if (hits[w])
				hit_way = way_t'(w);
		end
	end

	assign cache_hit_o = access_q && (|hits);
	assign data_o = way_lines[hit_way];
	assign miss = access_q && !(|hits);

	// Replacement
	assign used_way = cache_hit_o ? hit_way : victim_way;

	pseudo_lru i_pseudo_lru (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.lookup_set_i(set_q),
		.update_i(access_q),
		.update_set_i(set_q),
		.used_way_i(used_way),
		.victim_way_o(victim_way)
	);

	// Miss handling
	assign miss_req.set_idx = set_q;
	assign miss_req.way = victim_way;
	assign miss_req.req_tag = tag_q;
	assign miss_req.victim_tag = way_tags[victim_way];

	miss_engine i_miss_engine (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.miss_i(miss),
		.miss_req_i(miss_req),
		.l2_ack_i(l2_ack_i),
		.l2_data_i(l2_data_i),
		.l2_read_o(l2_read_o),
		.l2_write_o(l2_write_o),
		.l2_addr_o(l2_addr_o),
		.l2_data_o(l2_data_o),
		.ways_io(ways)
	);

	// Tags within a set stay unique
	single_hit: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		access_q |-> $onehot0(hits)
	)
	else
		$error("multiple ways hit in set %0d", set_q);

endmodule

//--- sim/tb_data_cache.sv
// Data cache testbench

`timescale 1ns/10ps

module tb_data_cache import dcache_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = 200;

	logic clk;
	logic arst_n_i;
	logic access_i;
	logic write_i;
	addr_t address_i;
	line_t data_i;
	mask_t write_mask_i;
	line_t data_o;
	logic cache_hit_o;
	logic l2_read_o;
	logic l2_write_o;
	addr_t l2_addr_o;
	line_t l2_data_o;
	line_t l2_data_i;
	logic l2_ack_i;

	// L2 contents and the expected view of memory
	line_t l2_mem [addr_t];
	line_t ref_mem [addr_t];
	addr_t log_addr [$];
	line_t log_data [$];
	int writes_done;
	int reads_done;

	int tests;
	int checks;
	int errors;
	logic timed_out;
	logic [31:0] lfsr_q;

	data_cache i_data_cache (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.access_i(access_i),
		.write_i(write_i),
		.address_i(address_i),
		.data_i(data_i),
		.write_mask_i(write_mask_i),
		.data_o(data_o),
		.cache_hit_o(cache_hit_o),
		.l2_read_o(l2_read_o),
		.l2_write_o(l2_write_o),
		.l2_addr_o(l2_addr_o),
		.l2_data_o(l2_data_o),
		.l2_data_i(l2_data_i),
		.l2_ack_i(l2_ack_i)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois LFSR stepped once per bit
	function automatic logic rand_bit();
		logic b;
		b = lfsr_q[0];
		if (lfsr_q[0])
			lfsr_q = (lfsr_q >> 1) ^ 32'hA3000000;
		else
			lfsr_q = lfsr_q >> 1;
		return b;
	endfunction

	function automatic line_t fill_line(addr_t a);
		line_t v;
		for (int i = 0; i < LINE_BITS; i++)
			v[i] = rand_bit();
		return v ^ {(LINE_BITS / ADDR_WIDTH){a}};
	endfunction

	// First touch of a line sets both the L2 and the expected copy
	function automatic void init_line(addr_t a);
		if (!l2_mem.exists(a))
		begin
			l2_mem[a] = fill_line(a);
			ref_mem[a] = l2_mem[a];
		end
	endfunction

	function automatic line_t merge_line(line_t old, line_t data, mask_t mask);
		line_t v;
		v = old;
		for (int b = 0; b < LINE_BYTES; b++)
		begin
			if (mask[b])
				v[b*8 +: 8] = data[b*8 +: 8];
		end
		return v;
	endfunction

	task automatic check_hit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch %s hit: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch %s line: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_l2_addr(input string name, input addr_t exp, input addr_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("mismatch %s L2 address: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Access in cycle N with results sampled in N+1
	task automatic do_access(input logic wr, input addr_t addr, input line_t data,
		input mask_t mask, output logic hit, output line_t line);
		@(posedge clk);
		access_i <= 1'b1;
		write_i <= wr;
		address_i <= addr;
		data_i <= data;
		write_mask_i <= mask;
		@(posedge clk);
		access_i <= 1'b0;
		write_i <= 1'b0;
		@(negedge clk);
		hit = cache_hit_o;
		line = data_o;
	endtask

	task automatic wait_l2(input logic want_write, input addr_t addr, output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			cycles++;
			ok = want_write ? (writes_done != 0) : (reads_done != 0);
		end
		if (!ok)
		begin
			timed_out = 1'b1;
			errors++;
			$display("timeout: L2 %s for line %h never came",
				want_write ? "write-back" : "read", addr);
		end
	endtask

	task automatic run_step(input string name, input logic wr, input addr_t addr,
		input logic [31:0] word, input mask_t mask, input logic exp_hit, input string wb_str);
		addr_t line_addr;
		addr_t wb_addr;
		logic wb_valid;
		line_t data;
		logic hit;
		line_t line;
		logic ok;
		int err_start;
		int n;

		line_addr = {addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
		wb_valid = (wb_str != "none");
		wb_addr = '0;
		err_start = errors;
		if (wb_valid)
		begin
			n = $sscanf(wb_str, "%h", wb_addr);
			if (n != 1)
			begin
				errors++;
				$display("%s: write-back address %s is not readable", name, wb_str);
			end
		end
		data = {(LINE_BITS / 32){word}};
		init_line(line_addr);
		writes_done = 0;
		reads_done = 0;
		log_addr.delete();
		log_data.delete();

		@(negedge clk);
		if (l2_read_o !== 1'b0 || l2_write_o !== 1'b0)
		begin
			errors++;
			$display("%s: L2 request already active before the access", name);
		end

		do_access(wr, addr, data, mask, hit, line);
		check_hit(name, exp_hit, hit);
		if (!hit)
		begin
			if (wb_valid)
			begin
				wait_l2(1'b1, wb_addr, ok);
				if (!ok)
					return;
				check_l2_addr(name, wb_addr, log_addr[0]);
				check_line(name, ref_mem[wb_addr], log_data[0]);
			end
			wait_l2(1'b0, line_addr, ok);
			if (!ok)
				return;
			check_l2_addr(name, line_addr, log_addr[log_addr.size() - 1]);
			if (log_addr.size() != (wb_valid ? 2 : 1))
			begin
				errors++;
				$display("%s: L2 saw %0d transactions for one miss", name, log_addr.size());
			end
			// Refilled line must hit now
			do_access(wr, addr, data, mask, hit, line);
			check_hit(name, 1'b1, hit);
		end
		if (hit)
		begin
			check_line(name, ref_mem[line_addr], line);
			if (wr)
				ref_mem[line_addr] = merge_line(ref_mem[line_addr], data, mask);
		end
		tests++;
		$display("test %-14s %s", name, (errors == err_start) ? "ok" : "has errors");
	endtask

	// L2 memory model with a random ack delay of 1 to 4 cycles
	initial
	begin : l2_model
		addr_t req_addr;
		line_t req_data;
		logic req_write;
		int delay;

		l2_ack_i = 1'b0;
		l2_data_i = '0;
		forever
		begin
			@(negedge clk);
			if (arst_n_i && (l2_read_o || l2_write_o))
			begin
				req_write = l2_write_o;
				req_addr = l2_addr_o;
				req_data = l2_data_o;
				delay = 1;
				if (rand_bit())
					delay += 1;
				if (rand_bit())
					delay += 2;
				repeat (delay) @(posedge clk);
				if (req_write)
				begin
					l2_mem[req_addr] = req_data;
				end
				else
				begin
					init_line(req_addr);
					l2_data_i <= l2_mem[req_addr];
				end
				l2_ack_i <= 1'b1;
				@(posedge clk);
				l2_ack_i <= 1'b0;
				log_addr.push_back(req_addr);
				log_data.push_back(req_data);
				if (req_write)
					writes_done++;
				else
					reads_done++;
			end
		end
	end

	initial
	begin
		int fd;
		int n;
		string line_str;
		string name;
		string rw;
		string wb_str;
		addr_t addr;
		logic [31:0] word;
		mask_t mask;
		int exp_hit;

		arst_n_i = 1'b0;
		access_i = 1'b0;
		write_i = 1'b0;
		address_i = '0;
		data_i = '0;
		write_mask_i = '0;
		lfsr_q = 32'd85150;
		tests = 0;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		writes_done = 0;
		reads_done = 0;

		repeat (RESET_CYCLES) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		if (cache_hit_o !== 1'b0 || l2_read_o !== 1'b0 || l2_write_o !== 1'b0)
		begin
			errors++;
			$display("hit or L2 request output is not low after reset");
		end

		fd = $fopen("sim/dcache_patterns.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("cannot open pattern file sim/dcache_patterns.txt");
		end
		else
		begin
			while (!timed_out && !$feof(fd))
			begin
				n = $fgets(line_str, fd);
				if (n > 0 && line_str.getc(0) != "#")
				begin
					n = $sscanf(line_str, "%s %s %h %h %h %d %s",
						name, rw, addr, word, mask, exp_hit, wb_str);
					if (n == 7)
						run_step(name, rw == "wr", addr, word, mask, exp_hit != 0, wb_str);
				end
			end
			$fclose(fd);
		end
		if (tests == 0)
		begin
			errors++;
			$display("no test steps were run");
		end

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- sim/dcache_patterns.txt
# name rw address data_word byte_mask expected_hit writeback_line
# mask bit n enables byte n, the word repeats over the line, writeback is none or a line address
cold_rd_a      rd 100000c4 00000000 0000000000000000 0 none
wr_a_low       wr 100000c0 a5a5a5a5 00000000000000ff 1 none
rd_a_merge     rd 100000c8 00000000 0000000000000000 1 none
wr_a_high      wr 100000f0 3c3c3c3c f000000000000000 1 none
rd_b_way2      rd 200008c0 00000000 0000000000000000 0 none
rd_c_way1      rd 300010c0 00000000 0000000000000000 0 none
rd_d_way3      rd 400018c0 00000000 0000000000000000 0 none
rd_e_evict_a   rd 500020c0 00000000 0000000000000000 0 100000c0
rd_a_again     rd 100000c4 00000000 0000000000000000 0 none
rd_a_hit       rd 100000c0 00000000 0000000000000000 1 none
rd_c_hit       rd 300010c0 00000000 0000000000000000 1 none
rd_b_again     rd 200008c0 00000000 0000000000000000 0 none
rd_d_again     rd 400018c0 00000000 0000000000000000 0 none
wr_x_miss      wr 00002a84 deadbeef 00000000ffff0000 0 none
rd_x_merge     rd 00002a80 00000000 0000000000000000 1 none
wr_x_again     wr 00002abc 12345678 0f0f0f0f0f0f0f0f 1 none
rd_y1          rd 00003280 00000000 0000000000000000 0 none
rd_y2          rd 00003a80 00000000 0000000000000000 0 none
rd_y3          rd 00004280 00000000 0000000000000000 0 none
rd_y4_evict_x  rd 00004a80 00000000 0000000000000000 0 00002a80
rd_x_refill    rd 00002a80 00000000 0000000000000000 0 none
rd_x_hit       rd 00002aa0 00000000 0000000000000000 1 none
wr_top_cold    wr fffff7c0 0badf00d ffffffffffffffff 0 none
rd_top         rd fffff7fc 00000000 0000000000000000 1 none
rd_zero        rd 00000000 00000000 0000000000000000 0 none
rd_zero_hit    rd 0000003f 00000000 0000000000000000 1 none

//--- sim.f
logic/dcache_pkg.sv
logic/way_if.sv
logic/cache_way.sv
logic/pseudo_lru.sv
logic/miss_engine.sv
logic/data_cache.sv
sim/tb_data_cache.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_data_cache
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
